//--- all.f
design/fetch_pkg.sv
design/fetch_addr_sel.sv
design/prefetch_buffer.sv
design/if_id_regs.sv
design/if_stage.sv
sim/tb_if_stage.sv

//--- design/fetch_addr_sel.sv
// next fetch address selection, purely combinational
// boot_addr_i and csr_mtvec_i must be aligned to the 256 byte trap granule
// mtvec_init_o is only meaningful when qualified by pc_set_i outside
module fetch_addr_sel #(
  parameter logic [fetch_pkg::XLEN-1:0] DmHaltAddr      = 32'h1A110800,
  parameter logic [fetch_pkg::XLEN-1:0] DmExceptionAddr = 32'h1A110808
) (
  input  logic [fetch_pkg::XLEN-1:0]    boot_addr_i,
  input  logic [fetch_pkg::XLEN-1:0]    branch_target_i,
  input  logic [fetch_pkg::XLEN-1:0]    csr_mepc_i,
  input  logic [fetch_pkg::XLEN-1:0]    csr_depc_i,
  input  logic [fetch_pkg::XLEN-1:0]    csr_mtvec_i,
  input  fetch_pkg::pc_sel_e            pc_mux_i,
  input  fetch_pkg::exc_pc_sel_e        exc_pc_mux_i,
  input  logic [fetch_pkg::IrqVecW-1:0] irq_vec_i,
  output logic [fetch_pkg::XLEN-1:0]    fetch_addr_n_o,
  output logic                          mtvec_init_o
);

  logic [fetch_pkg::XLEN-1:0] trap_base;
  logic [fetch_pkg::XLEN-1:0] irq_offset;
  logic [fetch_pkg::XLEN-1:0] boot_pc;
  logic [fetch_pkg::XLEN-1:0] exc_pc;

  // trap base with the granule bits cleared
  assign trap_base = {csr_mtvec_i[fetch_pkg::XLEN-1:fetch_pkg::VecAlignBits],
                      {fetch_pkg::VecAlignBits{1'b0}}};

  // boot entry sits at a fixed offset inside the boot granule
  assign boot_pc = {boot_addr_i[fetch_pkg::XLEN-1:fetch_pkg::VecAlignBits],
                    fetch_pkg::BootOffset};

  // vector number zero extended to full width
  always_comb begin
    irq_offset = '0;
    irq_offset[fetch_pkg::IrqVecW-1:0] = irq_vec_i;
  end

  ////////////////////////////////////////
  // exception target
  ////////////////////////////////////////

  always_comb begin
    unique case (exc_pc_mux_i)
      fetch_pkg::EXC_PC_EXC:     exc_pc = trap_base;
      // one instruction slot per vector
      fetch_pkg::EXC_PC_IRQ:     exc_pc = trap_base + irq_offset * fetch_pkg::InstrBytes;
      fetch_pkg::EXC_PC_DBD:     exc_pc = DmHaltAddr;
      fetch_pkg::EXC_PC_DBG_EXC: exc_pc = DmExceptionAddr;
      default:                   exc_pc = trap_base;
    endcase
  end

  ////////////////////////////////////////
  // next fetch address
  ////////////////////////////////////////

  always_comb begin
    unique case (pc_mux_i)
      fetch_pkg::PC_BOOT: fetch_addr_n_o = boot_pc;
      fetch_pkg::PC_JUMP: fetch_addr_n_o = branch_target_i;
      fetch_pkg::PC_EXC:  fetch_addr_n_o = exc_pc;
      // return from trap handler
      fetch_pkg::PC_ERET: fetch_addr_n_o = csr_mepc_i;
      // return from debug mode
      fetch_pkg::PC_DRET: fetch_addr_n_o = csr_depc_i;
      default:            fetch_addr_n_o = boot_pc;
    endcase
  end

  // csr file loads mtvec from the boot address on a boot redirect
  assign mtvec_init_o = (pc_mux_i == fetch_pkg::PC_BOOT);

  // no clock here, checks settle at the end of the time step
  always_comb begin
    a_boot_aligned: assert final (boot_addr_i[fetch_pkg::VecAlignBits-1:0] == '0)
      else $error("boot address low byte is not zero");
    a_exc_sel_known: assert final (!$isunknown(exc_pc_mux_i))
      else $error("exception target selector is unknown");
  end

endmodule

//--- design/fetch_pkg.sv
// shared widths, addresses and selector encodings for the fetch stage
// every instruction is 32 bits and word aligned, there is no compressed support
package fetch_pkg;

  ////////////////////////////////////////
  // widths and steps
  ////////////////////////////////////////

  // address and instruction word width
  localparam int unsigned XLEN = 32;

  // byte distance between two sequential instructions
  localparam int unsigned InstrBytes = 4;

  // trap base granule, low bits of mtvec and boot address are dropped
  localparam int unsigned VecAlignBits = 8;

  // interrupt vector number width
  localparam int unsigned IrqVecW = 5;

  // low byte that boot execution starts at
  localparam logic [VecAlignBits-1:0] BootOffset = 8'h80;

  ////////////////////////////////////////
  // selector encodings
  ////////////////////////////////////////

  // next fetch address source
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // kind of exception target
  // the two debug kinds point into the debug module
  typedef enum logic [1:0] {
    EXC_PC_EXC     = 2'd0,
    EXC_PC_IRQ     = 2'd1,
    EXC_PC_DBD     = 2'd2,
    EXC_PC_DBG_EXC = 2'd3
  } exc_pc_sel_e;

endpackage

//--- design/if_id_regs.sv
// IF-ID pipeline registers with valid and new flags
// the alert checks that each presented word follows pc_id_o by one instruction
// unless a redirect or a fetch error broke the sequence
module if_id_regs (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       fetch_valid_i,
  input  logic [fetch_pkg::XLEN-1:0] fetch_rdata_i,
  input  logic [fetch_pkg::XLEN-1:0] fetch_addr_i,
  input  logic                       fetch_err_i,
  input  logic                       id_in_ready_i,
  input  logic                       pc_set_i,
  input  logic                       instr_valid_clear_i,
  output logic                       fetch_ready_o,
  output logic                       instr_valid_id_o,
  output logic                       instr_new_id_o,
  output logic [fetch_pkg::XLEN-1:0] instr_rdata_id_o,
  output logic                       instr_fetch_err_o,
  output logic [fetch_pkg::XLEN-1:0] pc_id_o,
  output logic [fetch_pkg::XLEN-1:0] pc_if_o,
  output logic                       pc_mismatch_alert_o
);

  logic                       consume;
  logic                       instr_valid_d;
  logic                       prev_seq_d;
  logic                       prev_seq_q;
  logic [fetch_pkg::XLEN-1:0] seq_pc;

  // decode readiness goes straight back to the queue
  assign fetch_ready_o = id_in_ready_i;
  assign consume       = fetch_valid_i & id_in_ready_i;
  assign pc_if_o       = fetch_addr_i;

  // a word taken while redirecting is squashed
  // valid then holds until decode clears it
  assign instr_valid_d = (consume & ~pc_set_i) | (instr_valid_id_o & ~instr_valid_clear_i);

  ////////////////////////////////////////
  // pipeline registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_valid_id_o  <= 1'b0;
      instr_new_id_o    <= 1'b0;
      instr_rdata_id_o  <= '0;
      instr_fetch_err_o <= 1'b0;
      pc_id_o           <= '0;
    end else begin
      instr_valid_id_o <= instr_valid_d;
      // one cycle pulse per loaded word
      instr_new_id_o   <= consume;
      // frozen while decode stalls
      if (consume) begin
        instr_rdata_id_o  <= fetch_rdata_i;
        instr_fetch_err_o <= fetch_err_i;
        pc_id_o           <= fetch_addr_i;
      end
    end
  end

  ////////////////////////////////////////
  // sequential pc alert
  ////////////////////////////////////////

  // armed by a load, disarmed by redirect or by an erroneous word
  assign prev_seq_d = (prev_seq_q | consume) & ~pc_set_i & ~(fetch_valid_i & fetch_err_i);
  assign seq_pc     = pc_id_o + fetch_pkg::InstrBytes;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prev_seq_q <= 1'b0;
    end else begin
      prev_seq_q <= prev_seq_d;
    end
  end

  // only presented words count, the queue head is stale when empty
  assign pc_mismatch_alert_o = prev_seq_q & fetch_valid_i & (fetch_addr_i != seq_pc);

  // the queue is flushed at a redirect so no old word may follow it
  a_flush_on_redirect: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pc_set_i |=> !fetch_valid_i);

endmodule

//--- design/if_stage.sv
// instruction fetch stage top, address select, prefetch queue and IF-ID registers
// one bus master, 32-bit word aligned instructions only
// fetching starts with the first pc_set_i seen while req_i is high
module if_stage #(
  parameter logic [fetch_pkg::XLEN-1:0] DmHaltAddr      = 32'h1A110800,
  parameter logic [fetch_pkg::XLEN-1:0] DmExceptionAddr = 32'h1A110808,
  parameter int unsigned                FifoDepth       = 3
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic [fetch_pkg::XLEN-1:0]    boot_addr_i,
  input  logic                          req_i,
  // redirect control
  input  logic                          pc_set_i,
  input  fetch_pkg::pc_sel_e            pc_mux_i,
  input  fetch_pkg::exc_pc_sel_e        exc_pc_mux_i,
  input  logic [fetch_pkg::IrqVecW-1:0] irq_vec_i,
  input  logic [fetch_pkg::XLEN-1:0]    branch_target_ex_i,
  input  logic [fetch_pkg::XLEN-1:0]    csr_mepc_i,
  input  logic [fetch_pkg::XLEN-1:0]    csr_depc_i,
  input  logic [fetch_pkg::XLEN-1:0]    csr_mtvec_i,
  // instruction bus
  output logic                          instr_req_o,
  output logic [fetch_pkg::XLEN-1:0]    instr_addr_o,
  input  logic                          instr_gnt_i,
  input  logic                          instr_rvalid_i,
  input  logic [fetch_pkg::XLEN-1:0]    instr_rdata_i,
  input  logic                          instr_bus_err_i,
  // decode side
  input  logic                          id_in_ready_i,
  input  logic                          instr_valid_clear_i,
  output logic                          instr_valid_id_o,
  output logic                          instr_new_id_o,
  output logic [fetch_pkg::XLEN-1:0]    instr_rdata_id_o,
  output logic                          instr_fetch_err_o,
  output logic [fetch_pkg::XLEN-1:0]    pc_id_o,
  output logic [fetch_pkg::XLEN-1:0]    pc_if_o,
  output logic                          csr_mtvec_init_o,
  output logic                          pc_mismatch_alert_o,
  output logic                          if_busy_o
);

  logic [fetch_pkg::XLEN-1:0] fetch_addr_n;
  logic                       mtvec_init;
  logic                       fetch_valid;
  logic                       fetch_ready;
  logic [fetch_pkg::XLEN-1:0] fetch_rdata;
  logic [fetch_pkg::XLEN-1:0] fetch_addr;
  logic                       fetch_err;

  fetch_addr_sel #(
    .DmHaltAddr      (DmHaltAddr),
    .DmExceptionAddr (DmExceptionAddr)
  ) u_fetch_addr_sel (
    .boot_addr_i     (boot_addr_i),
    .branch_target_i (branch_target_ex_i),
    .csr_mepc_i      (csr_mepc_i),
    .csr_depc_i      (csr_depc_i),
    .csr_mtvec_i     (csr_mtvec_i),
    .pc_mux_i        (pc_mux_i),
    .exc_pc_mux_i    (exc_pc_mux_i),
    .irq_vec_i       (irq_vec_i),
    .fetch_addr_n_o  (fetch_addr_n),
    .mtvec_init_o    (mtvec_init)
  );

  // mtvec init only on an actual boot redirect
  assign csr_mtvec_init_o = pc_set_i & mtvec_init;

  // every redirect restarts the prefetch queue at the new address
  prefetch_buffer #(
    .FifoDepth      (FifoDepth)
  ) u_prefetch_buffer (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .branch_i       (pc_set_i),
    .branch_addr_i  (fetch_addr_n),
    .ready_i        (fetch_ready),
    .valid_o        (fetch_valid),
    .rdata_o        (fetch_rdata),
    .addr_o         (fetch_addr),
    .err_o          (fetch_err),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_err_i    (instr_bus_err_i),
    .busy_o         (if_busy_o)
  );

  if_id_regs u_if_id_regs (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .fetch_valid_i       (fetch_valid),
    .fetch_rdata_i       (fetch_rdata),
    .fetch_addr_i        (fetch_addr),
    .fetch_err_i         (fetch_err),
    .id_in_ready_i       (id_in_ready_i),
    .pc_set_i            (pc_set_i),
    .instr_valid_clear_i (instr_valid_clear_i),
    .fetch_ready_o       (fetch_ready),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o),
    .instr_rdata_id_o    (instr_rdata_id_o),
    .instr_fetch_err_o   (instr_fetch_err_o),
    .pc_id_o             (pc_id_o),
    .pc_if_o             (pc_if_o),
    .pc_mismatch_alert_o (pc_mismatch_alert_o)
  );

endmodule

//--- design/prefetch_buffer.sv
// word fetch engine with a small instruction queue
// at most one bus request is outstanding, a redirect flushes the queue
// and drops any response still in flight, FifoDepth must be 2 or more
module prefetch_buffer #(
  parameter int unsigned FifoDepth = 3
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       req_i,
  input  logic                       branch_i,
  input  logic [fetch_pkg::XLEN-1:0] branch_addr_i,
  input  logic                       ready_i,
  output logic                       valid_o,
  output logic [fetch_pkg::XLEN-1:0] rdata_o,
  output logic [fetch_pkg::XLEN-1:0] addr_o,
  output logic                       err_o,
  output logic                       instr_req_o,
  output logic [fetch_pkg::XLEN-1:0] instr_addr_o,
  input  logic                       instr_gnt_i,
  input  logic                       instr_rvalid_i,
  input  logic [fetch_pkg::XLEN-1:0] instr_rdata_i,
  input  logic                       instr_err_i,
  output logic                       busy_o
);

  localparam int unsigned PtrW   = $clog2(FifoDepth);
  localparam int unsigned CntW   = $clog2(FifoDepth + 1);
  localparam int unsigned AlignW = $clog2(fetch_pkg::InstrBytes);

  logic                       started_q;
  logic                       req_hold_q;
  logic                       outstanding_q;
  logic                       discard_q;
  logic [fetch_pkg::XLEN-1:0] fetch_addr_q;
  logic [fetch_pkg::XLEN-1:0] out_addr_q;

  logic [fetch_pkg::XLEN-1:0] addr_mem_q [FifoDepth];
  logic [fetch_pkg::XLEN-1:0] data_mem_q [FifoDepth];
  logic                       err_mem_q  [FifoDepth];
  logic [PtrW-1:0]            wr_ptr_q;
  logic [PtrW-1:0]            rd_ptr_q;
  logic [CntW-1:0]            count_q;

  logic room;
  logic issue;
  logic grant;
  logic push;
  logic pop;

  // wrap a queue pointer at the last slot
  function automatic logic [PtrW-1:0] ptr_inc(input logic [PtrW-1:0] ptr);
    if (ptr == PtrW'(FifoDepth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  ////////////////////////////////////////
  // bus request engine
  ////////////////////////////////////////

  // a free slot must exist for the word we ask for
  assign room  = (count_q < CntW'(FifoDepth));
  assign issue = req_i & started_q & ~outstanding_q & room;

  // a raised request stays up until granted
  assign instr_req_o  = req_hold_q | issue;
  assign instr_addr_o = fetch_addr_q;
  assign grant        = instr_req_o & instr_gnt_i;
  assign busy_o       = instr_req_o | outstanding_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      started_q     <= 1'b0;
      req_hold_q    <= 1'b0;
      outstanding_q <= 1'b0;
      discard_q     <= 1'b0;
      fetch_addr_q  <= '0;
      out_addr_q    <= '0;
    end else begin
      // idle after reset until the first redirect with req_i
      started_q  <= started_q | (branch_i & req_i);
      req_hold_q <= instr_req_o & ~instr_gnt_i;

      // grant and rvalid never coincide since only one word is in flight
      if (grant) begin
        outstanding_q <= 1'b1;
        out_addr_q    <= instr_addr_o;
      end else if (instr_rvalid_i) begin
        outstanding_q <= 1'b0;
      end

      // anything in flight or granted now belongs to the old path
      if (branch_i) begin
        discard_q <= (outstanding_q & ~instr_rvalid_i) | grant;
      end else if (instr_rvalid_i) begin
        discard_q <= 1'b0;
      end

      // redirect wins over the sequential step
      if (branch_i) begin
        fetch_addr_q <= {branch_addr_i[fetch_pkg::XLEN-1:AlignW], {AlignW{1'b0}}};
      end else if (grant) begin
        fetch_addr_q <= fetch_addr_q + fetch_pkg::InstrBytes;
      end
    end
  end

  ////////////////////////////////////////
  // instruction queue
  ////////////////////////////////////////

  // stale or redirected responses never enter the queue
  // error words are queued like any other, fetch carries on past them
  assign push = instr_rvalid_i & outstanding_q & ~discard_q & ~branch_i;
  assign pop  = valid_o & ready_i;

  assign valid_o = (count_q != '0);
  assign rdata_o = data_mem_q[rd_ptr_q];
  assign addr_o  = addr_mem_q[rd_ptr_q];
  assign err_o   = err_mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      for (int i = 0; i < FifoDepth; i++) begin
        addr_mem_q[i] <= '0;
        data_mem_q[i] <= '0;
        err_mem_q[i]  <= 1'b0;
      end
    end else if (branch_i) begin
      // flush, old entries are simply abandoned
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        addr_mem_q[wr_ptr_q] <= out_addr_q;
        data_mem_q[wr_ptr_q] <= instr_rdata_i;
        err_mem_q[wr_ptr_q]  <= instr_err_i;
        wr_ptr_q             <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      unique case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  a_addr_ok: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_o |-> (!$isunknown(instr_addr_o) && (instr_addr_o[AlignW-1:0] == '0)));

  // a new request waits for the response to the previous one
  a_one_outstanding: assert property (@(posedge clk_i) disable iff (!rst_ni)
    outstanding_q |-> !instr_req_o);

  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (push && !pop) |-> (count_q < CntW'(FifoDepth)));

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build the fetch stage testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_if_stage -Mdir obj_dir -f all.f

out="$(./obj_dir/Vtb_if_stage)"
echo "$out"

if grep -qx "STATUS: PASS" <<< "$out"; then
  exit 0
fi
exit 1

//--- sim/if_stage_stimulus.txt
// columns, all hex: command, operand a, operand b, expected entry pc, instructions to check
// 1 boot 2 jump 3 exc (a kind, b mtvec) 4 irq (a vector, b mtvec) 5 eret 6 dret
// 7 clear valid, 8 stall (a 1 on, 0 off), 9 bus error window [a, b)
9 00002010 00002018 00000000 0
1 00001000 00000000 00001080 8        // boot
8 00000001 00000000 00000000 0        // random stalls on
2 00002000 00000000 00002000 8        // jump across the error window
2 00003004 00000000 00003004 10       // jump
3 00000000 00004000 00004000 4        // exception
4 00000011 00004000 00004044 4        // irq vector 0x11
3 00000002 00000000 1a110800 3        // debug halt
3 00000003 00000000 1a110808 3        // debug exception
5 00005008 00000000 00005008 5        // eret
6 00006040 00000000 00006040 5        // dret
8 00000000 00000000 00000000 0        // stalls off
7 00000000 00000000 00000000 0        // clear
2 00000100 00000000 00000100 4        // jump
7 00000000 00000000 00000000 0        // clear

//--- sim/tb_if_stage.sv
// testbench for the fetch stage, commands and entry PCs from sim/if_stage_stimulus.txt
// memory word at address A is A ^ 32'h5A5A0000, bus error inside [err_lo, err_hi)
// the redirect cycle drives id_in_ready_i low so no old word can follow a redirect
module tb_if_stage;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int          ClkPeriod = 100;
  localparam int          CmdCycles = 2000;
  localparam int          MaxWords  = 320;
  localparam logic [31:0] DataMask  = 32'h5A5A0000;

  logic                          clk_i;
  logic                          rst_ni;
  logic                          req_i;
  logic                          pc_set_i;
  logic [31:0]                   boot_addr_i, branch_target_ex_i, csr_mepc_i, csr_depc_i;
  logic [31:0]                   csr_mtvec_i;
  fetch_pkg::pc_sel_e            pc_mux_i;
  fetch_pkg::exc_pc_sel_e        exc_pc_mux_i;
  logic [fetch_pkg::IrqVecW-1:0] irq_vec_i;
  logic                          instr_gnt_i, instr_rvalid_i, instr_bus_err_i;
  logic [31:0]                   instr_rdata_i;
  logic                          id_in_ready_i, instr_valid_clear_i;
  logic                          instr_req_o, instr_valid_id_o, instr_new_id_o;
  logic                          instr_fetch_err_o, csr_mtvec_init_o;
  logic                          pc_mismatch_alert_o, if_busy_o;
  logic [31:0]                   instr_addr_o, instr_rdata_id_o, pc_id_o, pc_if_o;

  // command table, five words per command, a zero command ends it
  logic [31:0] stim [MaxWords];
  int          n_cmd;
  int          errors;
  int          checks;
  int          entered;
  logic [31:0] rng;
  logic [31:0] err_lo, err_hi;
  logic [31:0] exp_pc, held_pc, held_rdata;
  logic [31:0] prev_pc_if;
  logic        exp_valid;
  logic        stalling;

  if_stage DUT (.*);

  initial begin : clock_gen
    clk_i = 1'b0;
    forever begin
      #(ClkPeriod / 2);
      clk_i = ~clk_i;
    end
  end

  // LCG step, result taken from the upper half
  function automatic int unsigned rand_below(input int unsigned span);
    rng = rng * 32'd1664525 + 32'd1013904223;
    return rng[31:16] % span;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  ////////////////////////////////////////
  // memory model
  ////////////////////////////////////////

  // grant after 0 to 3 cycles, rvalid 1 to 3 cycles after grant
  initial begin : memory_model
    int          gnt_wait;
    int          rsp_wait;
    logic [31:0] rsp_addr;
    gnt_wait = -1;
    rsp_wait = 0;
    rsp_addr = '0;
    forever begin
      @(posedge clk_i);
      #10;
      // busy covers a pending request and a word in flight
      check_value("if_busy_o", 32'(if_busy_o), 32'(instr_req_o || (rsp_wait > 0)));
      if (rsp_wait > 0) begin
        // only one word may be in flight
        check_value("instr_req_o", 32'(instr_req_o), 32'h0);
      end
      instr_gnt_i    = 1'b0;
      instr_rvalid_i = 1'b0;
      if (rsp_wait > 0) begin
        rsp_wait--;
        if (rsp_wait == 0) begin
          instr_rvalid_i  = 1'b1;
          instr_rdata_i   = rsp_addr ^ DataMask;
          instr_bus_err_i = (rsp_addr >= err_lo) && (rsp_addr < err_hi);
        end
      end else if (instr_req_o) begin
        if (gnt_wait < 0) begin
          gnt_wait = int'(rand_below(4));
        end
        if (gnt_wait == 0) begin
          instr_gnt_i = 1'b1;
          rsp_addr    = instr_addr_o;
          rsp_wait    = 1 + int'(rand_below(3));
          gnt_wait    = -1;
        end else begin
          gnt_wait--;
        end
      end
    end
  end

  ////////////////////////////////////////
  // ID side monitor and driver
  ////////////////////////////////////////

  // sample registered outputs, then drive the next cycle's inputs
  task automatic next_cycle();
    @(posedge clk_i);
    #10;
    check_value("pc_mismatch_alert_o", 32'(pc_mismatch_alert_o), 32'h0);
    if (instr_new_id_o) begin
      exp_valid = 1'b1;
      // queue head seen in the cycle before the load
      check_value("pc_if_o", prev_pc_if, exp_pc);
      check_value("pc_id_o", pc_id_o, exp_pc);
      check_value("instr_rdata_id_o", instr_rdata_id_o, exp_pc ^ DataMask);
      check_value("instr_fetch_err_o", 32'(instr_fetch_err_o),
                  32'((exp_pc >= err_lo) && (exp_pc < err_hi)));
      exp_pc = exp_pc + 32'd4;
      entered++;
    end else begin
      // nothing loaded, registers must hold
      check_value("pc_id_o", pc_id_o, held_pc);
      check_value("instr_rdata_id_o", instr_rdata_id_o, held_rdata);
    end
    check_value("instr_valid_id_o", 32'(instr_valid_id_o), 32'(exp_valid));
    held_pc             = pc_id_o;
    held_rdata          = instr_rdata_id_o;
    prev_pc_if          = pc_if_o;
    pc_set_i            = 1'b0;
    instr_valid_clear_i = 1'b0;
    id_in_ready_i       = stalling ? (rand_below(2) != 0) : 1'b1;
  endtask

  task automatic wait_entries(input int count);
    int cycles;
    cycles = 0;
    while (entered < count && cycles < CmdCycles) begin
      next_cycle();
      cycles++;
    end
    if (entered < count) begin
      errors++;
      $display("only %0d of %0d instructions entered in time", entered, count);
    end
  endtask

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  initial begin : stimulus
    logic [31:0] cmd, op_a, op_b;
    int          count;
    {req_i, pc_set_i, instr_gnt_i, instr_rvalid_i, instr_bus_err_i} = '0;
    {id_in_ready_i, instr_valid_clear_i, exp_valid, stalling} = '0;
    {boot_addr_i, branch_target_ex_i, csr_mepc_i, csr_depc_i, csr_mtvec_i} = '0;
    {instr_rdata_i, err_lo, err_hi, exp_pc, held_pc, held_rdata} = '0;
    prev_pc_if   = '0;
    pc_mux_i     = fetch_pkg::PC_BOOT;
    exc_pc_mux_i = fetch_pkg::EXC_PC_EXC;
    irq_vec_i    = '0;
    rng          = 32'h2e96;
    {errors, checks, entered} = '0;
    for (int i = 0; i < MaxWords; i++) begin
      stim[i] = '0;
    end
    $readmemh("sim/if_stage_stimulus.txt", stim);
    n_cmd = 0;
    while (n_cmd < MaxWords / 5 && stim[n_cmd * 5] != 0) begin
      n_cmd++;
    end
    rst_ni = 1'b0;
    repeat (10) @(posedge clk_i);
    #10;
    rst_ni = 1'b1;
    req_i  = 1'b1;
    // quiet outputs after reset, nothing fetched before the first redirect
    check_value("instr_req_o", 32'(instr_req_o), 32'h0);
    check_value("instr_new_id_o", 32'(instr_new_id_o), 32'h0);
    check_value("csr_mtvec_init_o", 32'(csr_mtvec_init_o), 32'h0);

    for (int c = 0; c < n_cmd; c++) begin
      cmd   = stim[c * 5];
      op_a  = stim[c * 5 + 1];
      op_b  = stim[c * 5 + 2];
      count = int'(stim[c * 5 + 4]);
      next_cycle();
      case (cmd)
        32'd1: begin
          boot_addr_i = op_a;
          pc_mux_i    = fetch_pkg::PC_BOOT;
        end
        32'd2: begin
          branch_target_ex_i = op_a;
          pc_mux_i           = fetch_pkg::PC_JUMP;
        end
        32'd3: begin
          exc_pc_mux_i = fetch_pkg::exc_pc_sel_e'(op_a[1:0]);
          csr_mtvec_i  = op_b;
          pc_mux_i     = fetch_pkg::PC_EXC;
        end
        32'd4: begin
          exc_pc_mux_i = fetch_pkg::EXC_PC_IRQ;
          irq_vec_i    = op_a[fetch_pkg::IrqVecW-1:0];
          csr_mtvec_i  = op_b;
          pc_mux_i     = fetch_pkg::PC_EXC;
        end
        32'd5: begin
          csr_mepc_i = op_a;
          pc_mux_i   = fetch_pkg::PC_ERET;
        end
        32'd6: begin
          csr_depc_i = op_a;
          pc_mux_i   = fetch_pkg::PC_DRET;
        end
        // valid drops at the next edge, nothing consumed meanwhile
        32'd7: begin
          instr_valid_clear_i = 1'b1;
          id_in_ready_i       = 1'b0;
          exp_valid           = 1'b0;
        end
        32'd8: stalling = op_a[0];
        32'd9: begin
          err_lo = op_a;
          err_hi = op_b;
        end
        default: begin
          errors++;
          $display("unknown command %0d in stimulus line %0d", cmd, c);
        end
      endcase
      if (cmd >= 32'd1 && cmd <= 32'd6) begin
        pc_set_i      = 1'b1;
        id_in_ready_i = 1'b0;
        exp_pc        = stim[c * 5 + 3];
        entered       = 0;
        #1;
        check_value("csr_mtvec_init_o", 32'(csr_mtvec_init_o), 32'(cmd == 32'd1));
        wait_entries(count);
      end
    end
    repeat (4) next_cycle();

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // bound scales with the number of commands
  initial begin : watchdog
    #1;
    #((n_cmd + 1) * CmdCycles * ClkPeriod);
    $display("timeout, stimulus did not complete in %0d cycles", (n_cmd + 1) * CmdCycles);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule
